// File: rtl/snes_mem_pkg.sv
`default_nettype none

package snes_mem_pkg;

    // external memory side
    localparam int mem_addr_w  = 23;    // byte address
    localparam int word_w      = 16;
    localparam int byte_w      = word_w / 2;

    // cpu side
    localparam int wram_addr_w = 17;    // 128 KB of work ram
    localparam int rom_addr_w  = 24;    // bit 23 is not used

    // work ram sits at the top 128 KB of the memory
    localparam logic [mem_addr_w-wram_addr_w-1:0] wram_base_hi = 6'b111111;

    // credit counter width, enough for up to 15 credits
    localparam int credit_w = 4;

    // rom loader states
    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_loading = 2'd1,
        st_loaded  = 2'd2
    } load_state_t;

endpackage

`default_nettype wire

// File: rtl/load_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module load_ctrl
    import snes_mem_pkg::*;
(
    input  logic mclk,
    input  logic resetn,
    input  logic loading,
    input  logic has_credit,
    input  logic room_for_cycle,
    output logic load_start,
    output logic loader_ready,
    output logic enable
);

    load_state_t state;
    load_state_t state_nxt;
    logic        loading_q;
    logic        load_end;
    logic        ready_q;       // loader_ready last cycle, a write may still be in flight

    assign load_start = loading & ~loading_q;
    assign load_end   = ~loading & loading_q;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (load_start)
                    state_nxt = st_loading;
            end
            st_loading: begin
                if (load_end)
                    state_nxt = st_loaded;
            end
            st_loaded: begin
                if (load_start)
                    state_nxt = st_loading;   // reload
            end
            default: state_nxt = st_idle;
        endcase
    end

    // with a single credit left only one loader write may be outstanding
    assign loader_ready = (state == st_loading) && has_credit
                          && (room_for_cycle || ~ready_q);

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state     <= st_idle;
            loading_q <= 1'b0;
            ready_q   <= 1'b0;
            enable    <= 1'b0;
        end else begin
            state     <= state_nxt;
            loading_q <= loading;
            ready_q   <= loader_ready;
            // drop enable on the same edge the state leaves loaded
            enable    <= (state == st_loaded) && room_for_cycle && ~load_start;
        end
    end

endmodule

`default_nettype wire

// File: rtl/credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module credit_counter
    import snes_mem_pkg::*;
#(
    parameter int num_credits = 4
) (
    input  logic mclk,
    input  logic resetn,
    input  logic take,          // request issued this cycle
    input  logic give,          // memory finished one request
    output logic has_credit,
    output logic room_for_cycle
);

    localparam logic [credit_w-1:0] max_credits = credit_w'(num_credits);

    logic [credit_w-1:0] count;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            count <= max_credits;
        end else if (take && !give) begin
            if (count != '0)
                count <= count - 1'b1;
        end else if (give && !take) begin
            if (count < max_credits)      // saturate, never above the pool
                count <= count + 1'b1;
        end
        // take and give together leave the count as it is
    end

    assign has_credit     = (count != '0);
    assign room_for_cycle = (count >= credit_w'(2));   // enough for a full cpu cycle

endmodule

`default_nettype wire

// File: rtl/mem_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter
    import snes_mem_pkg::*;
(
    input  logic                   mclk,
    input  logic                   resetn,
    input  logic                   enable,
    input  logic                   load_start,
    input  logic                   loading,
    input  logic [byte_w-1:0]      loader_do,
    input  logic                   loader_do_valid,
    input  logic                   loader_ready,
    input  logic                   sysclkf_ce,
    input  logic                   sysclkr_ce,
    input  logic                   rom_ce_n,
    input  logic [rom_addr_w-1:0]  rom_addr,
    input  logic                   rom_word,
    input  logic                   wram_ce_n,
    input  logic                   wram_rd_n,
    input  logic                   wram_we_n,
    input  logic [wram_addr_w-1:0] wram_addr,
    input  logic [byte_w-1:0]      wram_d,
    input  logic [word_w-1:0]      mem_port0,
    input  logic [word_w-1:0]      mem_port1,
    output logic [mem_addr_w-1:0]  mem_addr,
    output logic [word_w-1:0]      mem_din,
    output logic [1:0]             mem_ds,
    output logic                   mem_port,
    output logic                   mem_rd,
    output logic                   mem_wr,
    output logic [word_w-1:0]      rom_q,
    output logic [byte_w-1:0]      wram_q
);

    logic                  f2;          // fall phase, delayed one cycle
    logic                  r2;          // rise phase, delayed one cycle
    logic [mem_addr_w-1:0] load_addr;
    logic                  load_accept;
    logic                  wram_rd;
    logic                  wram_wr;
    logic                  wram_req;
    logic                  rom_req;

    assign load_accept = loading && loader_do_valid && loader_ready;

    assign wram_rd  = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr  = ~wram_ce_n & ~wram_we_n;
    assign wram_req = (wram_rd & f2) | (wram_wr & r2);  // reads on fall, writes on rise
    assign rom_req  = ~rom_ce_n & f2;

    // cpu phase strobes only count while the cpu is running
    always_ff @(posedge mclk) begin
        if (!resetn) begin
            f2 <= 1'b0;
            r2 <= 1'b0;
        end else begin
            f2 <= sysclkf_ce && enable;
            r2 <= sysclkr_ce && enable;
        end
    end

    // loader address, restarts with every load
    always_ff @(posedge mclk) begin
        if (!resetn)
            load_addr <= '0;
        else if (load_start)
            load_addr <= '0;
        else if (load_accept)
            load_addr <= load_addr + 1'b1;
    end

    // request strobes
    always_ff @(posedge mclk) begin
        if (!resetn) begin
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
        end else begin
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
            if (load_accept) begin
                mem_wr <= 1'b1;
            end else if (wram_req) begin
                mem_rd <= wram_rd & f2;
                mem_wr <= wram_wr & r2;
            end else if (rom_req) begin
                mem_rd <= 1'b1;
            end
        end
    end

    // request payload, same priority as the strobes
    always_ff @(posedge mclk) begin
        if (load_accept) begin
            mem_addr <= load_addr;
            mem_din  <= {loader_do, loader_do};
            mem_ds   <= {load_addr[0], ~load_addr[0]};
            mem_port <= 1'b0;
        end else if (wram_req) begin
            mem_addr <= {wram_base_hi, wram_addr};     // 7e/7f banks
            mem_din  <= {wram_d, wram_d};
            mem_ds   <= {wram_addr[0], ~wram_addr[0]};
            mem_port <= 1'b1;
        end else if (rom_req) begin
            mem_addr <= rom_addr[mem_addr_w-1:0];
            mem_ds   <= 2'b11;              // whole word
            mem_port <= 1'b0;
        end
    end

    // odd byte reads get the high byte in the low lane
    assign rom_q = (rom_word || ~rom_addr[0]) ? mem_port0
                 : {mem_port0[byte_w-1:0], mem_port0[word_w-1:byte_w]};

    assign wram_q = wram_addr[0] ? mem_port1[word_w-1:byte_w]
                                 : mem_port1[byte_w-1:0];

endmodule

`default_nettype wire

// File: rtl/snes_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module snes_mem_top
    import snes_mem_pkg::*;
#(
    parameter int num_credits = 4
) (
    input  logic                   mclk,
    input  logic                   resetn,

    // rom loader byte stream
    input  logic                   loading,
    input  logic [byte_w-1:0]      loader_do,
    input  logic                   loader_do_valid,
    output logic                   loader_ready,

    // cpu
    input  logic                   sysclkf_ce,
    input  logic                   sysclkr_ce,
    input  logic                   rom_ce_n,
    input  logic [rom_addr_w-1:0]  rom_addr,
    input  logic                   rom_word,
    output logic [word_w-1:0]      rom_q,
    input  logic                   wram_ce_n,
    input  logic                   wram_rd_n,
    input  logic                   wram_we_n,
    input  logic [wram_addr_w-1:0] wram_addr,
    input  logic [byte_w-1:0]      wram_d,
    output logic [byte_w-1:0]      wram_q,
    output logic                   enable,

    // shared memory request port
    output logic [mem_addr_w-1:0]  mem_addr,
    output logic [word_w-1:0]      mem_din,
    output logic [1:0]             mem_ds,
    output logic                   mem_port,
    output logic                   mem_rd,
    output logic                   mem_wr,
    input  logic [word_w-1:0]      mem_port0,
    input  logic [word_w-1:0]      mem_port1,
    input  logic                   mem_credit
);

    logic has_credit;
    logic room_for_cycle;
    logic load_start;
    logic mem_take;

    assign mem_take = mem_rd | mem_wr;  // every request costs one credit

    load_ctrl u_load_ctrl (
        .mclk           (mclk),
        .resetn         (resetn),
        .loading        (loading),
        .has_credit     (has_credit),
        .room_for_cycle (room_for_cycle),
        .load_start     (load_start),
        .loader_ready   (loader_ready),
        .enable         (enable)
    );

    credit_counter #(
        .num_credits (num_credits)
    ) u_credit_counter (
        .mclk           (mclk),
        .resetn         (resetn),
        .take           (mem_take),
        .give           (mem_credit),
        .has_credit     (has_credit),
        .room_for_cycle (room_for_cycle)
    );

    mem_port_arbiter u_arbiter (
        .mclk            (mclk),
        .resetn          (resetn),
        .enable          (enable),
        .load_start      (load_start),
        .loading         (loading),
        .loader_do       (loader_do),
        .loader_do_valid (loader_do_valid),
        .loader_ready    (loader_ready),
        .sysclkf_ce      (sysclkf_ce),
        .sysclkr_ce      (sysclkr_ce),
        .rom_ce_n        (rom_ce_n),
        .rom_addr        (rom_addr),
        .rom_word        (rom_word),
        .wram_ce_n       (wram_ce_n),
        .wram_rd_n       (wram_rd_n),
        .wram_we_n       (wram_we_n),
        .wram_addr       (wram_addr),
        .wram_d          (wram_d),
        .mem_port0       (mem_port0),
        .mem_port1       (mem_port1),
        .mem_addr        (mem_addr),
        .mem_din         (mem_din),
        .mem_ds          (mem_ds),
        .mem_port        (mem_port),
        .mem_rd          (mem_rd),
        .mem_wr          (mem_wr),
        .rom_q           (rom_q),
        .wram_q          (wram_q)
    );

endmodule

`default_nettype wire

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic mclk,
    output logic resetn
);

    initial begin
        mclk   = 1'b0;
        resetn = 1'b0;
        repeat (16) @(posedge mclk);
        #1 resetn = 1'b1;    // released just after an edge
    end

    always #2 mclk = ~mclk;  // 4 ns period

endmodule

`default_nettype wire

// File: bench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import snes_mem_pkg::*;
(
    input  logic                  mclk,
    input  logic                  resetn,
    input  logic                  row_go,
    input  logic [2:0]            row_kind,
    input  logic [rom_addr_w-1:0] row_addr,
    input  logic [word_w-1:0]     row_data,
    input  logic [word_w-1:0]     row_exp,
    input  logic                  credit_hold,
    input  logic                  loading,
    input  logic                  loader_ready,
    input  logic                  enable,
    input  logic [mem_addr_w-1:0] mem_addr,
    input  logic [word_w-1:0]     mem_din,
    input  logic [1:0]            mem_ds,
    input  logic                  mem_port,
    input  logic                  mem_rd,
    input  logic                  mem_wr,
    input  logic [word_w-1:0]     rom_q,
    input  logic [byte_w-1:0]     wram_q,
    output int                    tests_done,
    output int                    errors
);

    localparam logic [2:0] k_load    = 3'd0;
    localparam logic [2:0] k_wram_rd = 3'd1;
    localparam logic [2:0] k_wram_wr = 3'd2;
    localparam logic [2:0] k_rom     = 3'd3;
    localparam logic [2:0] k_hold    = 3'd4;

    int   row_err;
    int   load_idx;
    logic load_seen;
    logic loading_q;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED row %0d %s got %h expected %h", tests_done, name, got, want);
            row_err++;
        end
    endtask

    task automatic wait_request(output logic found);
        found = 1'b0;
        for (int n = 0; n < 30 && !found; n++) begin
            @(negedge mclk);
            found = mem_rd | mem_wr;
        end
        if (!found) begin
            $display("row %0d saw no memory request", tests_done);
            row_err++;
        end
    endtask

    // all sampling on the falling edge, away from the driven edges
    initial begin : watch
        logic found;
        int   cnt;
        tests_done = 0;
        errors     = 0;
        load_idx   = 0;
        load_seen  = 1'b0;
        loading_q  = 1'b0;
        forever begin
            @(negedge mclk);
            if (resetn && !load_seen && (mem_rd | mem_wr | enable | loader_ready)) begin
                $display("memory side active before the first load");
                errors++;
                load_seen = 1'b1;
            end
            if (loading && !loading_q) begin
                load_idx  = 0;          // new image starts at address 0
                load_seen = 1'b1;
            end
            loading_q = loading;
            if (row_go) begin
                row_err = 0;
                case (row_kind)
                    k_load: begin
                        wait_request(found);
                        if (found) begin
                            compare_field("mem_wr", mem_wr, 1);
                            compare_field("mem_addr", mem_addr, load_idx);
                            compare_field("mem_din", mem_din, {row_data[7:0], row_data[7:0]});
                            compare_field("mem_ds", mem_ds, row_exp[1:0]);
                            compare_field("mem_port", mem_port, 0);
                        end
                        load_idx++;
                    end
                    k_wram_rd, k_wram_wr: begin
                        wait_request(found);
                        if (found) begin
                            // top 128 KB of the memory
                            compare_field("mem_addr", mem_addr,
                                          23'h7e0000 | row_addr[wram_addr_w-1:0]);
                            compare_field("mem_port", mem_port, 1);
                            if (row_kind == k_wram_rd) begin
                                compare_field("mem_rd", mem_rd, 1);
                                compare_field("mem_ds", mem_ds,
                                              row_addr[0] ? 2'b10 : 2'b01);
                                compare_field("wram_q", wram_q, row_exp[7:0]);
                            end else begin
                                compare_field("mem_wr", mem_wr, 1);
                                compare_field("mem_din", mem_din,
                                              {row_data[7:0], row_data[7:0]});
                                compare_field("mem_ds", mem_ds, row_exp[1:0]);
                            end
                        end
                    end
                    k_rom: begin
                        wait_request(found);
                        if (found) begin
                            compare_field("mem_rd", mem_rd, 1);
                            compare_field("mem_addr", mem_addr, row_addr[mem_addr_w-1:0]);
                            compare_field("mem_ds", mem_ds, 2'b11);
                            compare_field("mem_port", mem_port, 0);
                            compare_field("rom_q", rom_q, row_exp);
                        end
                    end
                    k_hold: begin
                        cnt = 0;
                        while (credit_hold) begin
                            @(negedge mclk);
                            if (credit_hold && (mem_rd | mem_wr))
                                cnt++;
                        end
                        compare_field("requests", cnt, row_exp);
                        if (enable) begin
                            $display("row %0d enable still high while credits held", tests_done);
                            row_err++;
                        end
                        cnt = 0;
                        while (!enable && cnt < 20) begin
                            @(negedge mclk);
                            cnt++;
                        end
                        if (!enable) begin
                            $display("row %0d enable did not return with credits", tests_done);
                            row_err++;
                        end
                    end
                    default: begin
                        $display("row %0d has an unknown kind", tests_done);
                        row_err++;
                    end
                endcase
                $display("row %0d kind %0d %s", tests_done, row_kind,
                         (row_err == 0) ? "ok" : "mismatch");
                errors += row_err;
                tests_done++;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/snes_mem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module snes_mem_assert
    import snes_mem_pkg::*;
(
    input logic        mclk,
    input logic        resetn,
    input logic        mem_rd,
    input logic        mem_wr,
    input logic        has_credit,
    input logic        enable,
    input load_state_t load_state
);

    int fail_count = 0;

    a_one_request: assert property (@(posedge mclk) disable iff (!resetn)
        !(mem_rd && mem_wr))
        else begin
            fail_count++;
            $error("mem_rd and mem_wr high in the same cycle");
        end

    // the request's own credit is still counted while it is on the port
    a_credit: assert property (@(posedge mclk) disable iff (!resetn)
        (mem_rd || mem_wr) |-> has_credit)
        else begin
            fail_count++;
            $error("memory request issued with no credit left");
        end

    a_enable: assert property (@(posedge mclk) disable iff (!resetn)
        enable |-> (load_state == st_loaded))
        else begin
            fail_count++;
            $error("enable high outside the loaded state");
        end

endmodule

bind snes_mem_top snes_mem_assert u_assert (
    .mclk       (mclk),
    .resetn     (resetn),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .has_credit (has_credit),
    .enable     (enable),
    .load_state (u_load_ctrl.state)
);

`default_nettype wire

// File: bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import snes_mem_pkg::*;
;

    localparam int num_credits = 4;
    localparam int num_rows    = 22;
    localparam int mem_depth   = num_credits * 16;
    localparam int idx_w       = $clog2(mem_depth);

    localparam logic [2:0] k_load    = 3'd0;
    localparam logic [2:0] k_wram_rd = 3'd1;
    localparam logic [2:0] k_wram_wr = 3'd2;
    localparam logic [2:0] k_rom     = 3'd3;
    localparam logic [2:0] k_hold    = 3'd4;

    typedef struct packed {
        logic [2:0]  kind;
        logic [23:0] addr;
        logic [15:0] data;
        logic [15:0] exp_val;
    } row_t;

    logic mclk;
    logic resetn;
    logic loading, loader_do_valid, loader_ready;
    logic [byte_w-1:0] loader_do;
    logic sysclkf_ce, sysclkr_ce, rom_ce_n, rom_word;
    logic [rom_addr_w-1:0] rom_addr;
    logic [word_w-1:0] rom_q;
    logic wram_ce_n, wram_rd_n, wram_we_n;
    logic [wram_addr_w-1:0] wram_addr;
    logic [byte_w-1:0] wram_d, wram_q;
    logic enable;
    logic [mem_addr_w-1:0] mem_addr;
    logic [word_w-1:0] mem_din, mem_port0, mem_port1;
    logic [1:0] mem_ds;
    logic mem_port, mem_rd, mem_wr, mem_credit;

    row_t rows [num_rows];
    int   n_rows;
    logic row_go, credit_hold;
    logic [2:0] row_kind;
    logic [rom_addr_w-1:0] row_addr;
    logic [word_w-1:0] row_data, row_exp;
    int   tests_done, errors;

    logic [word_w-1:0] mem_arr [mem_depth];
    integer seed;
    int owed;
    logic [2:0] ret_pipe;

    tb_clkgen u_clkgen (.mclk(mclk), .resetn(resetn));

    snes_mem_top #(.num_credits(num_credits)) dut (
        .mclk(mclk), .resetn(resetn),
        .loading(loading), .loader_do(loader_do), .loader_do_valid(loader_do_valid),
        .loader_ready(loader_ready),
        .sysclkf_ce(sysclkf_ce), .sysclkr_ce(sysclkr_ce),
        .rom_ce_n(rom_ce_n), .rom_addr(rom_addr), .rom_word(rom_word), .rom_q(rom_q),
        .wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n), .wram_we_n(wram_we_n),
        .wram_addr(wram_addr), .wram_d(wram_d), .wram_q(wram_q), .enable(enable),
        .mem_addr(mem_addr), .mem_din(mem_din), .mem_ds(mem_ds), .mem_port(mem_port),
        .mem_rd(mem_rd), .mem_wr(mem_wr),
        .mem_port0(mem_port0), .mem_port1(mem_port1), .mem_credit(mem_credit)
    );

    tb_checker u_checker (
        .mclk(mclk), .resetn(resetn), .row_go(row_go), .row_kind(row_kind),
        .row_addr(row_addr), .row_data(row_data), .row_exp(row_exp),
        .credit_hold(credit_hold), .loading(loading), .loader_ready(loader_ready),
        .enable(enable), .mem_addr(mem_addr), .mem_din(mem_din), .mem_ds(mem_ds),
        .mem_port(mem_port), .mem_rd(mem_rd), .mem_wr(mem_wr), .rom_q(rom_q),
        .wram_q(wram_q), .tests_done(tests_done), .errors(errors)
    );

    // memory model, one credit back about four cycles after each request
    initial begin : memory_model
        logic [idx_w-1:0] k;
        seed = 74;
        for (int i = 0; i < mem_depth; i++)
            mem_arr[i] = 16'($random(seed));
        owed       = 0;
        ret_pipe   = '0;
        mem_credit = 1'b0;
        mem_port0  = '0;
        mem_port1  = '0;
        forever begin
            @(posedge mclk);
            #1;
            mem_credit = 1'b0;
            if (ret_pipe[2])
                owed++;
            ret_pipe = {ret_pipe[1:0], mem_rd | mem_wr};
            k = mem_addr[idx_w:1];
            if (mem_wr) begin
                if (mem_ds[0]) mem_arr[k][7:0]  = mem_din[7:0];
                if (mem_ds[1]) mem_arr[k][15:8] = mem_din[15:8];
            end
            if (mem_rd) begin
                if (mem_port) mem_port1 = mem_arr[k];
                else          mem_port0 = mem_arr[k];
            end
            if (owed > 0 && !credit_hold) begin
                mem_credit = 1'b1;
                owed--;
            end
        end
    end

    task automatic add_row(input logic [2:0] kind, input logic [23:0] addr,
                           input logic [15:0] data, input logic [15:0] exp_val);
        rows[n_rows] = {kind, addr, data, exp_val};
        n_rows++;
    endtask

    task automatic tick;
        @(posedge mclk);
        #1;
    endtask

    task automatic apply_row(input row_t r);
        logic ready_seen;
        if (r.kind == k_load && !loading) begin
            loading = 1'b1;
            repeat (3) tick();
        end else if (r.kind != k_load && loading) begin
            loading = 1'b0;
        end
        while (r.kind != k_load && !enable)
            tick();
        row_kind = r.kind;
        row_addr = r.addr;
        row_data = r.data;
        row_exp  = r.exp_val;
        case (r.kind)
            k_load: begin
                loader_do       = r.data[7:0];
                loader_do_valid = 1'b1;
            end
            k_wram_rd: begin
                wram_addr  = r.addr[wram_addr_w-1:0];
                wram_ce_n  = 1'b0;
                wram_rd_n  = 1'b0;
                sysclkf_ce = 1'b1;
            end
            k_wram_wr: begin
                wram_addr  = r.addr[wram_addr_w-1:0];
                wram_d     = r.data[7:0];
                wram_ce_n  = 1'b0;
                wram_we_n  = 1'b0;
                sysclkr_ce = 1'b1;
            end
            k_rom: begin
                rom_addr   = r.addr;
                rom_word   = r.data[0];
                rom_ce_n   = 1'b0;
                sysclkf_ce = 1'b1;
            end
            default: begin
                credit_hold = 1'b1;
                rom_addr    = '0;
                rom_ce_n    = 1'b0;
            end
        endcase
        row_go = 1'b1;
        @(posedge mclk);
        ready_seen = loader_ready;
        #1;
        row_go     = 1'b0;
        sysclkf_ce = 1'b0;
        sysclkr_ce = 1'b0;
        if (r.kind == k_load) begin
            while (!ready_seen) begin     // byte held until taken
                @(posedge mclk);
                ready_seen = loader_ready;
                #1;
            end
            loader_do_valid = 1'b0;
        end
        if (r.kind == k_hold) begin
            for (int p = 0; p < 8; p++) begin
                sysclkf_ce = 1'b1;
                tick();
                sysclkf_ce = 1'b0;
                repeat (5) tick();        // cpu cycle of six mclk
            end
            credit_hold = 1'b0;
        end
    endtask

    initial begin : stimulus
        loading         = 1'b0;
        loader_do       = '0;
        loader_do_valid = 1'b0;
        sysclkf_ce      = 1'b0;
        sysclkr_ce      = 1'b0;
        rom_word        = 1'b0;
        rom_ce_n        = 1'b1;
        rom_addr        = '0;
        wram_ce_n       = 1'b1;
        wram_rd_n       = 1'b1;
        wram_we_n       = 1'b1;
        wram_addr       = '0;
        wram_d          = '0;
        row_go          = 1'b0;
        credit_hold     = 1'b0;
        row_kind        = '0;
        row_addr        = '0;
        row_data        = '0;
        row_exp         = '0;
        n_rows          = 0;
        // kind, address, data, expected (lanes, read data or request count)
        add_row(k_load, 0, 16'ha1, 2'b01);
        add_row(k_load, 1, 16'hb2, 2'b10);
        add_row(k_load, 2, 16'hc3, 2'b01);
        add_row(k_load, 3, 16'hd4, 2'b10);
        add_row(k_rom, 2, 1, 16'hd4c3);
        add_row(k_load, 0, 16'h11, 2'b01);
        add_row(k_load, 1, 16'h22, 2'b10);
        add_row(k_load, 2, 16'h33, 2'b01);
        add_row(k_load, 3, 16'h44, 2'b10);
        add_row(k_load, 4, 16'h55, 2'b01);
        add_row(k_load, 5, 16'h66, 2'b10);
        add_row(k_rom, 0, 0, 16'h2211);
        add_row(k_rom, 1, 0, 16'h1122);    // odd byte comes back swapped
        add_row(k_rom, 3, 1, 16'h4433);
        add_row(k_rom, 4, 0, 16'h6655);
        add_row(k_rom, 5, 0, 16'h5566);
        add_row(k_wram_wr, 24'h41, 16'h5a, 2'b10);
        add_row(k_wram_wr, 24'h40, 16'hc3, 2'b01);
        add_row(k_wram_rd, 24'h41, 0, 16'h5a);
        add_row(k_wram_rd, 24'h40, 0, 16'hc3);
        add_row(k_hold, 0, 0, num_credits - 1);
        add_row(k_rom, 4, 0, 16'h6655);
        wait (resetn);
        repeat (4) tick();
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
            while (tests_done <= i)
                tick();
            wram_ce_n = 1'b1;
            wram_rd_n = 1'b1;
            wram_we_n = 1'b1;
            rom_ce_n  = 1'b1;
            repeat (6) tick();            // let credits drain back
        end
        $display("done: %0d tests, %0d check errors, %0d assertion failures",
                 tests_done, errors, dut.u_assert.fail_count);
        if (errors == 0 && dut.u_assert.fail_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial begin : watchdog
        repeat (num_rows * 40) @(posedge mclk);
        $display("timeout after %0d cycles, the run did not finish", num_rows * 40);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/snes_mem_pkg.sv
rtl/load_ctrl.sv
rtl/credit_counter.sv
rtl/mem_port_arbiter.sv
rtl/snes_mem_top.sv
bench/tb_clkgen.sv
bench/tb_checker.sv
bench/snes_mem_assert.sv
bench/tb_top.sv

// File: Makefile
# verilator build and run of the memory request testbench

TOP = tb_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, fail unless the pass line appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir
